//--- rtl/exec_params.svh
// Width and flow-control constants for the execute stage.
// EXEC_CREDIT_W must be wide enough to hold the value EXEC_CREDITS itself.
// The writeback stage has to provide exactly EXEC_CREDITS result slots.

`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// ---------------------------------------------------------------------------
// Datapath
// ---------------------------------------------------------------------------
`define EXEC_XLEN       32      // Data word width, RV32 only

// ---------------------------------------------------------------------------
// Credit flow control toward writeback
// ---------------------------------------------------------------------------
`define EXEC_CREDITS    2       // Result slots held by writeback
`define EXEC_CREDIT_W   2       // Counter width, holds 0..EXEC_CREDITS

`endif

//--- rtl/exec_pkg.sv
// Types shared by the execute stage and its testbench.
// OP_TAKEN and OP_NOT_TAKEN only appear on the result side, never as input.

`default_nettype none

`include "exec_params.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0] word_t;      // One data word

    // Micro-op encoding, 5 bits
    typedef enum logic [4:0] {
        OP_ADD,                                 // ALU group
        OP_SUB,
        OP_XOR,
        OP_OR,
        OP_AND,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_BEQ,                                 // Conditional branches
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_JAL,                                 // Unconditional jumps
        OP_JALR,
        OP_LOAD,                                // Memory address path
        OP_STORE,
        OP_MUL,                                 // Multiplier
        OP_MULH,
        OP_MULHU,
        OP_TAKEN,                               // Branch outcome, output only
        OP_NOT_TAKEN
    } exec_op_e;

    // Functional unit picked by decode
    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_BRANCH,
        UNIT_LSU,
        UNIT_MUL
    } exec_unit_e;

endpackage

`default_nettype wire

//--- rtl/exec_alu.sv
// Single-cycle ALU, purely combinational.
// Shift amounts use only the low log2(XLEN) bits of the right operand.
// The lt flag is unsigned for SLTU, BLTU and BGEU and signed otherwise.

`timescale 1ns/1ns
`default_nettype none

`include "exec_params.svh"

module exec_alu (
    input  exec_pkg::exec_op_e  i_op,
    input  exec_pkg::word_t     i_lhs,
    input  exec_pkg::word_t     i_rhs,
    output exec_pkg::word_t     o_result,
    output exec_pkg::word_t     o_sum,
    output logic                o_lt,
    output logic                o_eq
);
    import exec_pkg::*;

    localparam int SHW = $clog2(`EXEC_XLEN);   // Shift amount width

    logic           cmp_unsigned;
    logic [SHW-1:0] shamt;
    word_t          diff;

    assign cmp_unsigned = (i_op == OP_SLTU) || (i_op == OP_BLTU) || (i_op == OP_BGEU);
    assign shamt        = i_rhs[SHW-1:0];

    assign o_sum = i_lhs + i_rhs;               // Also address and jalr base
    assign diff  = i_lhs - i_rhs;
    assign o_eq  = (i_lhs == i_rhs);
    assign o_lt  = cmp_unsigned ? (i_lhs < i_rhs)
                                : ($signed(i_lhs) < $signed(i_rhs));

    // -----------------------------------------------------------------------
    // Result mux
    // -----------------------------------------------------------------------
    always_comb begin
        case (i_op)
            OP_ADD:          o_result = o_sum;
            OP_SUB:          o_result = diff;
            OP_XOR:          o_result = i_lhs ^ i_rhs;
            OP_OR:           o_result = i_lhs | i_rhs;
            OP_AND:          o_result = i_lhs & i_rhs;
            OP_SLL:          o_result = i_lhs << shamt;
            OP_SRL:          o_result = i_lhs >> shamt;
            OP_SRA:          o_result = word_t'($signed(i_lhs) >>> shamt);   // Sign fill
            OP_SLT, OP_SLTU: o_result = {{(`EXEC_XLEN-1){1'b0}}, o_lt};
            default:         o_result = '0;    // Not an ALU op
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/exec_branch.sv
// Branch condition and jump target, combinational.
// Relies on the ALU flags, whose signedness is already set by the opcode.

`timescale 1ns/1ns
`default_nettype none

module exec_branch (
    input  exec_pkg::exec_op_e  i_op,
    input  wire logic           i_lt,
    input  wire logic           i_eq,
    input  exec_pkg::word_t     i_sum,
    input  exec_pkg::word_t     i_target,
    output logic                o_taken,
    output exec_pkg::word_t     o_target
);
    import exec_pkg::*;

    word_t raw_target;

    always_comb begin
        case (i_op)
            OP_BEQ:            o_taken = i_eq;
            OP_BNE:            o_taken = !i_eq;
            OP_BLT, OP_BLTU:   o_taken = i_lt;
            OP_BGE, OP_BGEU:   o_taken = !i_lt;
            OP_JAL, OP_JALR:   o_taken = 1'b1;  // Jumps always go
            default:           o_taken = 1'b0;
        endcase
    end

    assign raw_target = (i_op == OP_JALR) ? i_sum : i_target;   // jalr is rs1 + imm
    assign o_target   = {raw_target[$bits(word_t)-1:1], 1'b0}; // Bit 0 cleared

endmodule

`default_nettype wire

//--- rtl/exec_mul.sv
// Iterative shift-add multiplier, one partial product per cycle.
// mul and mulh are signed x signed, mulhu is unsigned x unsigned.
// o_done comes 32 cycles after i_start, the last step is combinational.
// i_start must not arrive while a multiply is running.

`timescale 1ns/1ns
`default_nettype none

`include "exec_params.svh"

module exec_mul (
    input  wire logic           g_clk,
    input  wire logic           g_resetn,
    input  wire logic           i_start,
    input  exec_pkg::exec_op_e  i_op,
    input  exec_pkg::word_t     i_a,
    input  exec_pkg::word_t     i_b,
    output logic                o_done,
    output logic [2*`EXEC_XLEN-1:0] o_product
);
    import exec_pkg::*;

    localparam int CW = $clog2(`EXEC_XLEN);    // Step counter width

    logic                       op_signed;
    logic                       a_neg;
    logic                       b_neg;
    word_t                      a_mag;
    word_t                      b_mag;
    logic                       busy;
    logic [CW-1:0]              step_cnt;       // Steps already committed
    word_t                      mcand;          // Multiplicand magnitude
    word_t                      acc_hi;         // Upper half of running product
    word_t                      acc_lo;         // Multiplier bits shift out here
    logic                       neg_res;        // Signs differ
    logic [`EXEC_XLEN:0]        part_sum;
    logic [2*`EXEC_XLEN-1:0]    step_prod;

    assign op_signed = (i_op == OP_MUL) || (i_op == OP_MULH);
    assign a_neg     = op_signed && i_a[`EXEC_XLEN-1];
    assign b_neg     = op_signed && i_b[`EXEC_XLEN-1];
    assign a_mag     = a_neg ? -i_a : i_a;     // Most negative value stays as 2^31
    assign b_mag     = b_neg ? -i_b : i_b;

    // One shift-add step
    assign part_sum  = {1'b0, acc_hi} + (acc_lo[0] ? {1'b0, mcand} : '0);
    assign step_prod = {part_sum, acc_lo[`EXEC_XLEN-1:1]};

    assign o_done    = busy && (step_cnt == CW'(`EXEC_XLEN - 1));
    assign o_product = neg_res ? -step_prod : step_prod;   // Sign fixup

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            busy     <= 1'b0;
            step_cnt <= '0;
        end else if (i_start) begin
            busy     <= 1'b1;
            step_cnt <= '0;
        end else if (busy) begin
            busy     <= !o_done;                // Last step is consumed outside
            step_cnt <= step_cnt + 1'b1;
        end
    end

    always_ff @(posedge g_clk) begin
        if (i_start) begin
            mcand   <= a_mag;
            acc_hi  <= '0;
            acc_lo  <= b_mag;
            neg_res <= a_neg ^ b_neg;
        end else if (busy) begin
            {acc_hi, acc_lo} <= step_prod;
        end
    end

endmodule

`default_nettype wire

//--- rtl/exec_ctrl.sv
// Decode, credit accounting and the output register of the execute stage.
// One credit is taken at acceptance, so a result never waits for room.
// Only one multiply can be in flight and it blocks all later instructions.

`timescale 1ns/1ns
`default_nettype none

`include "exec_params.svh"

module exec_ctrl (
    input  wire logic               g_clk,
    input  wire logic               g_resetn,
    input  wire logic               i_valid,
    input  exec_pkg::exec_op_e      i_op,
    input  wire logic [4:0]         i_rd,
    input  exec_pkg::word_t         i_opr_c,
    input  wire logic               i_credit,
    output logic                    o_busy,
    output logic                    o_valid,
    output logic [4:0]              o_rd,
    output exec_pkg::exec_op_e      o_op,
    output exec_pkg::word_t         o_res_a,
    output exec_pkg::word_t         o_res_b,
    input  exec_pkg::word_t         i_alu_result,
    input  exec_pkg::word_t         i_alu_sum,
    input  wire logic               i_br_taken,
    input  exec_pkg::word_t         i_br_target,
    output logic                    o_mul_start,
    input  wire logic               i_mul_done,
    input  wire logic [2*`EXEC_XLEN-1:0] i_mul_product
);
    import exec_pkg::*;

    exec_unit_e                 unit;           // Decoded functional unit
    logic                       accept;         // Instruction taken this cycle
    logic                       is_cond;        // Conditional branch
    logic                       mul_busy;       // Multiply in flight
    logic                       mul_hi;         // Held op wants high word
    logic [`EXEC_CREDIT_W-1:0]  credit_cnt;     // Free writeback slots
    exec_op_e                   n_op;
    word_t                      n_res_a;
    word_t                      n_res_b;

    // -----------------------------------------------------------------------
    // Decode
    // -----------------------------------------------------------------------
    always_comb begin
        case (i_op)
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
            OP_BLTU, OP_BGEU, OP_JAL, OP_JALR:  unit = UNIT_BRANCH;
            OP_LOAD, OP_STORE:                  unit = UNIT_LSU;
            OP_MUL, OP_MULH, OP_MULHU:          unit = UNIT_MUL;
            default:                            unit = UNIT_ALU;
        endcase
    end

    assign is_cond     = (unit == UNIT_BRANCH) && (i_op != OP_JAL) && (i_op != OP_JALR);
    assign o_busy      = mul_busy || (credit_cnt == '0);    // No credit, no entry
    assign accept      = i_valid && !o_busy;
    assign o_mul_start = accept && (unit == UNIT_MUL);
    assign mul_hi      = (o_op == OP_MULH) || (o_op == OP_MULHU);  // o_op holds mul op

    // Result selection for single-cycle units
    always_comb begin
        n_op    = i_op;
        n_res_a = i_alu_result;
        n_res_b = '0;
        case (unit)
            UNIT_BRANCH: begin
                n_res_a = i_br_target;
                if (is_cond) begin
                    n_op = i_br_taken ? OP_TAKEN : OP_NOT_TAKEN;
                end
            end
            UNIT_LSU: begin
                n_res_a = i_alu_sum;                // Effective address
                if (i_op == OP_STORE) begin
                    n_res_b = i_opr_c;              // Store data
                end
            end
            default: ;                              // ALU as set above
        endcase
    end

    // -----------------------------------------------------------------------
    // Credits, multiply flag, output valid
    // -----------------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            credit_cnt <= `EXEC_CREDIT_W'(`EXEC_CREDITS);
            mul_busy   <= 1'b0;
            o_valid    <= 1'b0;
        end else begin
            case ({accept, i_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;   // Slot reserved
                2'b01:   credit_cnt <= credit_cnt + 1'b1;   // Slot returned
                default: ;                                  // Both or neither
            endcase
            if (o_mul_start) begin
                mul_busy <= 1'b1;
            end else if (i_mul_done) begin
                mul_busy <= 1'b0;
            end
            o_valid <= (accept && (unit != UNIT_MUL)) || i_mul_done;
        end
    end

    // Output payload, rd and op of a multiply wait here until done
    always_ff @(posedge g_clk) begin
        if (accept) begin
            o_rd <= i_rd;
            o_op <= n_op;
            if (unit != UNIT_MUL) begin
                o_res_a <= n_res_a;
                o_res_b <= n_res_b;
            end
        end else if (i_mul_done) begin
            o_res_a <= mul_hi ? i_mul_product[2*`EXEC_XLEN-1:`EXEC_XLEN]
                              : i_mul_product[`EXEC_XLEN-1:0];
            o_res_b <= i_mul_product[2*`EXEC_XLEN-1:`EXEC_XLEN];
        end
    end

endmodule

`default_nettype wire

//--- rtl/exec_top.sv
// Execute stage of the in-order pipeline.
// Input side is busy/valid, output side is credit based with no stall.
// Multiplies hold the stage for 33 cycles, everything else takes 1.

`timescale 1ns/1ns
`default_nettype none

`include "exec_params.svh"

module exec_top (
    input  wire logic               g_clk,
    input  wire logic               g_resetn,
    input  wire logic               i_valid,
    input  exec_pkg::exec_op_e      i_op,
    input  wire logic [4:0]         i_rd,
    input  exec_pkg::word_t         i_opr_a,
    input  exec_pkg::word_t         i_opr_b,
    input  exec_pkg::word_t         i_opr_c,
    input  wire logic               i_credit,
    output logic                    o_busy,
    output logic                    o_valid,
    output logic [4:0]              o_rd,
    output exec_pkg::exec_op_e      o_op,
    output exec_pkg::word_t         o_res_a,
    output exec_pkg::word_t         o_res_b
);
    import exec_pkg::*;

    word_t                      alu_result;     // ALU op result
    word_t                      alu_sum;        // Raw A + B
    logic                       alu_lt;         // A < B, signedness from op
    logic                       alu_eq;         // A == B
    logic                       br_taken;       // Condition met
    word_t                      br_target;      // Bit 0 already cleared
    logic                       mul_start;
    logic                       mul_done;
    logic [2*`EXEC_XLEN-1:0]    mul_product;

    // -----------------------------------------------------------------------
    // Control and output register
    // -----------------------------------------------------------------------
    exec_ctrl ctrl_inst (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .i_valid       (i_valid),
        .i_op          (i_op),
        .i_rd          (i_rd),
        .i_opr_c       (i_opr_c),
        .i_credit      (i_credit),
        .o_busy        (o_busy),
        .o_valid       (o_valid),
        .o_rd          (o_rd),
        .o_op          (o_op),
        .o_res_a       (o_res_a),
        .o_res_b       (o_res_b),
        .i_alu_result  (alu_result),
        .i_alu_sum     (alu_sum),
        .i_br_taken    (br_taken),
        .i_br_target   (br_target),
        .o_mul_start   (mul_start),
        .i_mul_done    (mul_done),
        .i_mul_product (mul_product)
    );

    // -----------------------------------------------------------------------
    // Datapaths
    // -----------------------------------------------------------------------
    exec_alu alu_inst (
        .i_op     (i_op),
        .i_lhs    (i_opr_a),
        .i_rhs    (i_opr_b),
        .o_result (alu_result),
        .o_sum    (alu_sum),
        .o_lt     (alu_lt),
        .o_eq     (alu_eq)
    );

    exec_branch branch_inst (
        .i_op     (i_op),
        .i_lt     (alu_lt),
        .i_eq     (alu_eq),
        .i_sum    (alu_sum),
        .i_target (i_opr_c),                    // PC-relative target from decode
        .o_taken  (br_taken),
        .o_target (br_target)
    );

    exec_mul mul_inst (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .i_start   (mul_start),
        .i_op      (i_op),
        .i_a       (i_opr_a),
        .i_b       (i_opr_b),
        .o_done    (mul_done),
        .o_product (mul_product)
    );

endmodule

`default_nettype wire

//--- bench/tb_exec_model.sv
// Result model of the execute stage, with the queue of expected results.
// Every accepted instruction is pushed with the cycle its result is due.
// mul is signed x signed like mulh, so both give the same high word.

`timescale 1ns/1ns
`default_nettype none

`include "exec_params.svh"

module tb_exec_model;
    import exec_pkg::*;

    localparam int MUL_LATENCY = 33;            // Accept to result, multiply

    logic [4:0] q_rd[$];                        // Expected results, in order
    exec_op_e   q_op[$];
    word_t      q_res_a[$];
    word_t      q_res_b[$];
    int         q_due[$];                       // Cycle of the o_valid pulse
    string      q_tag[$];                       // Name used in error lines
    int         n_pushed = 0;

    function automatic exec_unit_e unit_of(input exec_op_e op);
        case (op)
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
            OP_BLTU, OP_BGEU, OP_JAL, OP_JALR: return UNIT_BRANCH;
            OP_LOAD, OP_STORE:                 return UNIT_LSU;
            OP_MUL, OP_MULH, OP_MULHU:         return UNIT_MUL;
            default:                           return UNIT_ALU;
        endcase
    endfunction

    // Apply the result rules to one accepted instruction
    task automatic push_instr(input exec_op_e op, input logic [4:0] rd, input word_t a,
                              input word_t b, input word_t c, input int cycle);
        exec_op_e                eop;
        word_t                   ra;
        word_t                   rb;
        word_t                   all_ones;
        logic                    taken;
        int                      sh;
        longint                  sa;
        longint                  sb;
        logic [2*`EXEC_XLEN-1:0] prod;
        eop      = op;
        ra       = '0;
        rb       = '0;
        all_ones = '1;
        taken    = 1'b0;
        sh       = int'(b % `EXEC_XLEN);        // Shift amount modulo width
        sa       = $signed(a);                  // Sign extended to 64 bits
        sb       = $signed(b);
        case (op)
            OP_ADD:   ra = a + b;
            OP_SUB:   ra = a - b;
            OP_XOR:   ra = a ^ b;
            OP_OR:    ra = a | b;
            OP_AND:   ra = a & b;
            OP_SLL:   ra = a << sh;
            OP_SRL:   ra = a >> sh;
            OP_SRA:   ra = (a >> sh) | (a[`EXEC_XLEN-1] ? ~(all_ones >> sh) : '0);
            OP_SLT:   ra = ($signed(a) < $signed(b)) ? 1 : 0;
            OP_SLTU:  ra = (a < b) ? 1 : 0;
            OP_BEQ:   taken = (a == b);
            OP_BNE:   taken = (a != b);
            OP_BLT:   taken = ($signed(a) < $signed(b));
            OP_BGE:   taken = ($signed(a) >= $signed(b));
            OP_BLTU:  taken = (a < b);
            OP_BGEU:  taken = (a >= b);
            OP_JAL:   ra = c & ~word_t'(1);
            OP_JALR:  ra = (a + b) & ~word_t'(1);
            OP_LOAD:  ra = a + b;
            OP_STORE: begin
                ra = a + b;                     // Address
                rb = c;                         // Store data
            end
            OP_MUL: begin
                prod = sa * sb;
                ra   = prod[`EXEC_XLEN-1:0];
                rb   = prod[2*`EXEC_XLEN-1:`EXEC_XLEN];
            end
            OP_MULH: begin
                prod = sa * sb;
                ra   = prod[2*`EXEC_XLEN-1:`EXEC_XLEN];
                rb   = ra;
            end
            OP_MULHU: begin
                prod = {{`EXEC_XLEN{1'b0}}, a} * {{`EXEC_XLEN{1'b0}}, b};
                ra   = prod[2*`EXEC_XLEN-1:`EXEC_XLEN];
                rb   = ra;
            end
            default: ;
        endcase
        if (unit_of(op) == UNIT_BRANCH && op != OP_JAL && op != OP_JALR) begin
            eop = taken ? OP_TAKEN : OP_NOT_TAKEN;   // Outcome replaces opcode
            ra  = c & ~word_t'(1);
        end
        q_rd.push_back(rd);
        q_op.push_back(eop);
        q_res_a.push_back(ra);
        q_res_b.push_back(rb);
        q_due.push_back(cycle + ((unit_of(op) == UNIT_MUL) ? MUL_LATENCY : 1));
        q_tag.push_back($sformatf("#%0d %s", n_pushed, op.name()));
        n_pushed++;
    endtask

    task automatic pop_expected(output logic [4:0] rd, output exec_op_e op, output word_t ra,
                                output word_t rb, output int due, output string tag);
        rd  = q_rd.pop_front();
        op  = q_op.pop_front();
        ra  = q_res_a.pop_front();
        rb  = q_res_b.pop_front();
        due = q_due.pop_front();
        tag = q_tag.pop_front();
    endtask

    function automatic int pending();
        return q_op.size();
    endfunction

    function automatic int front_due();
        return q_due[0];                        // Only valid when pending
    endfunction

endmodule

`default_nettype wire

//--- bench/tb_exec.sv
// Testbench for the execute stage with random instructions and a result model.
// Writeback is modelled as an EXEC_CREDITS deep buffer that returns credits at random.
// Inputs change on rising edges only and outputs are read at rising edges.

`timescale 1ns/1ns
`default_nettype none

`include "exec_params.svh"

module tb_exec;
    import exec_pkg::*;

    localparam int  NUM_INSTR   = 2000;
    localparam int  MUL_LATENCY = 33;
    localparam time TIMEOUT     = NUM_INSTR * 40 * 100;    // 40 cycles of 100 ns per instruction

    logic       g_clk = 1'b0;
    logic       g_resetn;
    logic       i_valid;
    exec_op_e   i_op;
    logic [4:0] i_rd;
    word_t      i_opr_a;
    word_t      i_opr_b;
    word_t      i_opr_c;
    logic       i_credit;
    logic       o_busy;
    logic       o_valid;
    logic [4:0] o_rd;
    exec_op_e   o_op;
    word_t      o_res_a;
    word_t      o_res_b;

    int         cycle   = 0;                    // Cycles since reset release
    int         credits = `EXEC_CREDITS;        // Model of the DUT credit count
    int         wb_fill = 0;                    // Results held by writeback
    int         mul_due = 0;                    // Cycle the running multiply ends

    exec_top exec_top_inst (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_valid  (i_valid),
        .i_op     (i_op),
        .i_rd     (i_rd),
        .i_opr_a  (i_opr_a),
        .i_opr_b  (i_opr_b),
        .i_opr_c  (i_opr_c),
        .i_credit (i_credit),
        .o_busy   (o_busy),
        .o_valid  (o_valid),
        .o_rd     (o_rd),
        .o_op     (o_op),
        .o_res_a  (o_res_a),
        .o_res_b  (o_res_b)
    );

    tb_exec_model model_inst ();

    always #50 g_clk = ~g_clk;                  // 100 ns period

    // -----------------------------------------------------------------------
    // Failure reporting and compare tasks
    // -----------------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_op(input string name, input exec_op_e exp, input exec_op_e act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s expected %s actual %s (%0d)",
                                name, exp.name(), act.name(), act));
        end
    endtask

    task automatic check_rd(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    // -----------------------------------------------------------------------
    // Stimulus
    // -----------------------------------------------------------------------
    function automatic word_t rand_word();
        case ($urandom_range(0, 7))
            0:       return {1'b1, {(`EXEC_XLEN-1){1'b0}}};   // Most negative
            1:       return '1;
            2:       return '0;
            default: return $urandom;
        endcase
    endfunction

    task automatic present_instr();
        word_t a;
        word_t b;
        a = rand_word();
        b = ($urandom_range(0, 3) == 0) ? a : rand_word();    // Equal compares
        i_op    <= exec_op_e'($urandom_range(0, int'(OP_MULHU)));
        i_rd    <= 5'($urandom_range(0, 31));
        i_opr_a <= a;
        i_opr_b <= b;
        i_opr_c <= $urandom;
        i_valid <= ($urandom_range(0, 3) != 0);
    endtask

    task automatic compare_result();
        logic [4:0] e_rd;
        exec_op_e   e_op;
        word_t      e_a;
        word_t      e_b;
        int         e_due;
        string      tag;
        if (model_inst.pending() == 0) begin
            abort_run($sformatf("o_valid pulsed in cycle %0d with no result outstanding",
                                cycle));
        end
        model_inst.pop_expected(e_rd, e_op, e_a, e_b, e_due, tag);
        if (cycle != e_due) begin
            abort_run($sformatf("Result of %s arrived in cycle %0d, expected in cycle %0d",
                                tag, cycle, e_due));
        end
        check_rd({tag, " rd"}, e_rd, o_rd);
        check_op({tag, " op"}, e_op, o_op);
        check_word({tag, " res_a"}, e_a, o_res_a);
        check_word({tag, " res_b"}, e_b, o_res_b);
    endtask

    initial begin
        int sent;
        void'($urandom(19));
        sent     = 0;
        g_resetn = 1'b0;
        i_valid  = 1'b0;
        i_op     = OP_ADD;
        i_rd     = '0;
        i_opr_a  = '0;
        i_opr_b  = '0;
        i_opr_c  = '0;
        i_credit = 1'b0;
        repeat (10) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(negedge g_clk);
        if (o_valid !== 1'b0 || o_busy !== 1'b0) begin
            abort_run("o_valid or o_busy is not low after reset");
        end
        @(posedge g_clk);
        present_instr();
        while (sent < NUM_INSTR) begin
            @(posedge g_clk);
            if (i_valid && !o_busy) begin       // Accepted at this edge
                sent++;
                if (sent < NUM_INSTR) begin
                    present_instr();
                end else begin
                    i_valid <= 1'b0;
                end
            end else if (!i_valid) begin
                i_valid <= ($urandom_range(0, 3) != 0);
            end
        end
        @(negedge g_clk);                       // Monitor has run for the last edge
        while (model_inst.pending() != 0) begin
            @(negedge g_clk);
        end
        repeat (4) @(posedge g_clk);            // Catch stray o_valid pulses
        $display("sim passed");
        $finish;
    end

    // -----------------------------------------------------------------------
    // Monitor, credit return and scoreboard
    // -----------------------------------------------------------------------
    always @(posedge g_clk) begin : monitor
        logic exp_busy;
        if (g_resetn) begin
            cycle++;
            exp_busy = ((mul_due != 0) && (cycle < mul_due)) || (credits == 0);
            if (o_busy !== exp_busy) begin
                abort_run($sformatf("o_busy is %b in cycle %0d but should be %b",
                                    o_busy, cycle, exp_busy));
            end
            if (o_valid) begin
                compare_result();
                wb_fill++;                      // Writeback takes the result
            end else if (model_inst.pending() != 0 && model_inst.front_due() <= cycle) begin
                abort_run($sformatf("Expected result missing in cycle %0d", cycle));
            end
            if (i_credit) begin
                wb_fill--;                      // Slot returned to the DUT
                credits++;
            end
            if (wb_fill > `EXEC_CREDITS) begin
                abort_run($sformatf("%0d results outstanding, only %0d credits exist",
                                    wb_fill, `EXEC_CREDITS));
            end
            if (i_valid && !o_busy) begin
                model_inst.push_instr(i_op, i_rd, i_opr_a, i_opr_b, i_opr_c, cycle);
                credits--;                      // Reserved at acceptance
                if (model_inst.unit_of(i_op) == UNIT_MUL) begin
                    mul_due = cycle + MUL_LATENCY;
                end
            end
            i_credit <= (wb_fill != 0) && ($urandom_range(0, 2) != 0);
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        abort_run($sformatf("Timeout, the run did not finish within %0d ns", TIMEOUT));
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+rtl
rtl/exec_pkg.sv
rtl/exec_alu.sv
rtl/exec_branch.sv
rtl/exec_mul.sv
rtl/exec_ctrl.sv
rtl/exec_top.sv
bench/tb_exec_model.sv
bench/tb_exec.sv

//--- Bender.yml
package:
  name: exec_stage

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/exec_pkg.sv
      - rtl/exec_alu.sv
      - rtl/exec_branch.sv
      - rtl/exec_mul.sv
      - rtl/exec_ctrl.sv
      - rtl/exec_top.sv
      - target: test
        files:
          - bench/tb_exec_model.sv
          - bench/tb_exec.sv
